// File: dv/gcm_tb_ref.svh
`ifndef GCM_TB_REF_SVH
`define GCM_TB_REF_SVH

// GF(2^128) product, bit 127 holds the x^0 coefficient
function automatic logic [127:0] gf_mult(
    input logic [127:0] x,
    input logic [127:0] y
);
    logic [127:0] z;
    logic [127:0] v;
    logic         carry;
    z = 128'h0;
    v = x;
    for (int i = 127; i >= 0; i--) begin
        if (y[i]) begin
            z = z ^ v;                                  // Add x times x^(127-i)
        end
        carry = v[0];
        v     = {1'b0, v[127:1]};                       // Multiply by x
        if (carry) begin
            v[127:120] = v[127:120] ^ 8'he1;            // x^128 = 1 + x + x^2 + x^7
        end
    end
    return z;
endfunction

// Tag over n ciphertext blocks with no AAD
function automatic logic [127:0] gcm_ref_tag(
    input logic [127:0] h,
    input logic [127:0] mask,
    input logic [127:0] blks [16],
    input int           n
);
    logic [127:0] x;
    logic [63:0]  bit_len;
    x       = 128'h0;
    bit_len = 64'(n) * 64'd128;
    for (int i = 0; i < n; i++) begin
        x = gf_mult(x ^ blks[i], h);                    // Horner step per block
    end
    x = gf_mult(x ^ {64'h0, bit_len}, h);               // Length block, AAD length zero
    return x ^ mask;
endfunction

`endif

// File: dv/gcm_tb.sv
`timescale 1ns/1ps

module gcm_tb;
    import gcm_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int EXP_DATA_LAT   = 11;                 // Input beat to output beat
    localparam int EXP_TAG_LAT    = 14;                 // Last beat to tag strobe
    localparam int PKT_SPACING    = 15;                 // Last beat to next start
    localparam int MAX_GAP        = 3;                  // Random idle cycles before a beat
    localparam int N_PKTS         = 10;
    localparam int N_BEATS        = 42;                 // All beats of all packets
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_BEATS * (1 + MAX_GAP)
                                  + N_PKTS * (PKT_SPACING + 3) + EXP_TAG_LAT + 100;

    localparam logic [1:0] TAG_CAPTURE = 2'd0;          // Only record the tag
    localparam logic [1:0] TAG_EQUAL   = 2'd1;
    localparam logic [1:0] TAG_DIFFER  = 2'd2;

    // Constants for key 0 and IV 0 from the GCM test vectors
    localparam logic [127:0] H0    = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam logic [127:0] MASK0 = 128'h58e2fccefa7e3061367f1d57a4e7455a;
    localparam logic [127:0] CT0   = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam logic [127:0] TAG0  = 128'hab6e47d42cec13bdf53a67b21257bddf;

    typedef struct packed {
        logic [127:0] data;
        logic         chk;                              // Compare data or only capture it
        logic         first;
        logic         last;
        logic [31:0]  cycle;                            // Cycle the beat must show up
    } beat_exp_t;

    typedef struct packed {
        logic [127:0] tag;
        logic [1:0]   mode;
        logic [31:0]  cycle;
    } tag_exp_t;

    logic         i_clock = 1'b0;
    logic         i_reset;
    logic         i_start;
    logic         i_valid;
    logic         i_last;
    logic [127:0] i_data;
    logic [127:0] i_key;
    logic [95:0]  i_iv;
    gcm_dir_e     i_dir;
    logic         o_valid;
    logic [127:0] o_data;
    logic         o_start;
    logic         o_last;
    logic         o_tag_ready;
    logic [127:0] o_tag;

    integer       seed;
    logic [31:0]  cycle_cnt = '0;
    beat_exp_t    beat_q [$];
    tag_exp_t     tag_q [$];
    logic [127:0] tx_blk [16];                          // Beats of the next packet
    logic [127:0] exp_blk [16];                         // Their expected outputs
    logic [127:0] rx_cap [16];                          // Outputs of the latest packet
    logic [127:0] ks [16];                              // Keystream for key 0 and IV 0
    logic [127:0] pt3 [16];
    logic [127:0] ct3 [16];
    logic [127:0] pt5 [16];
    logic [127:0] ct5 [16];
    logic [127:0] pt6 [16];
    logic [127:0] ref_blk [16];
    logic [127:0] tag3;
    logic [127:0] tag5;
    logic [127:0] key5;
    logic [127:0] iv5;
    logic [127:0] last_tag;
    logic         data_chk;
    logic [1:0]   tag_mode;
    logic [127:0] tag_val;
    int           cap_idx = 0;

    `include "gcm_tb_ref.svh"

    gcm_core uut (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .i_data      (i_data),
        .i_key       (i_key),
        .i_iv        (i_iv),
        .i_dir       (i_dir),
        .o_valid     (o_valid),
        .o_data      (o_data),
        .o_start     (o_start),
        .o_last      (o_last),
        .o_tag_ready (o_tag_ready),
        .o_tag       (o_tag)
    );

    always #10 i_clock = ~i_clock;                      // 20 ns period

    task automatic stop_on_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_block(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_cycle(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("** Error at %0t ns: %s in cycle %0d, expected cycle %0d",
                     $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    always @(posedge i_clock) begin
        cycle_cnt <= cycle_cnt + 1'b1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("** Error at %0t ns: run did not finish within %0d cycles",
                     $time, TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    function automatic logic [127:0] rand_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Start strobe and beats from tx_blk followed by idle cycles up to the minimum spacing
    task automatic send_packet(input logic [127:0] key, input logic [95:0] iv,
                               input gcm_dir_e dir, input int n_blk, input logic gaps);
        int        gap;
        beat_exp_t be;
        tag_exp_t  te;
        @(negedge i_clock);
        i_start = 1'b1;
        i_key   = key;
        i_iv    = iv;
        i_dir   = dir;
        @(negedge i_clock);
        i_start = 1'b0;
        for (int i = 0; i < n_blk; i++) begin
            if (gaps) begin
                gap = $random(seed) & MAX_GAP;
                repeat (gap) @(negedge i_clock);
            end
            i_valid  = 1'b1;
            i_data   = tx_blk[i];
            i_last   = (i == n_blk - 1);
            be.data  = exp_blk[i];
            be.chk   = data_chk;
            be.first = (i == 0);
            be.last  = (i == n_blk - 1);
            be.cycle = cycle_cnt + EXP_DATA_LAT;
            beat_q.push_back(be);
            if (i == n_blk - 1) begin
                te.tag   = tag_val;
                te.mode  = tag_mode;
                te.cycle = cycle_cnt + EXP_TAG_LAT;
                tag_q.push_back(te);
            end
            @(negedge i_clock);
            i_valid = 1'b0;
            i_last  = 1'b0;
        end
        repeat (PKT_SPACING - 2) @(negedge i_clock);    // Next start lands at last + 15
    endtask

    task automatic wait_drain();
        @(negedge i_clock);
        while (beat_q.size() != 0 || tag_q.size() != 0) begin
            @(negedge i_clock);
        end
    endtask

    // Scoreboard samples at the falling edge
    always @(negedge i_clock) begin : monitor
        beat_exp_t be;
        tag_exp_t  te;
        if (i_reset === 1'b0) begin
            if (o_valid === 1'b1) begin
                assert (beat_q.size() > 0) else begin
                    $display("** Error at %0t ns: o_valid set with no beat expected", $time);
                    stop_on_failure();
                end
                be = beat_q.pop_front();
                check_cycle("o_valid", cycle_cnt, be.cycle);
                check_flag("o_start", o_start, be.first);
                check_flag("o_last", o_last, be.last);
                if (be.chk) begin
                    check_block("o_data", o_data, be.data);
                end
                if (o_start === 1'b1) begin
                    cap_idx = 0;
                end
                rx_cap[cap_idx] = o_data;               // Kept for keystream and round trip
                cap_idx         = cap_idx + 1;
            end
            if (o_tag_ready === 1'b1) begin
                assert (tag_q.size() > 0) else begin
                    $display("** Error at %0t ns: o_tag_ready set with no tag expected", $time);
                    stop_on_failure();
                end
                te = tag_q.pop_front();
                check_cycle("o_tag_ready", cycle_cnt, te.cycle);
                if (te.mode == TAG_EQUAL) begin
                    check_block("o_tag", o_tag, te.tag);
                end else if (te.mode == TAG_DIFFER) begin
                    assert (o_tag !== te.tag) else begin
                        $display("** Error at %0t ns: o_tag %h did not change with a flipped bit",
                                 $time, o_tag);
                        stop_on_failure();
                    end
                end
                last_tag = o_tag;
            end
        end
    end

    initial begin
        seed     = 32'hbd23d498;
        i_reset  = 1'b1;
        i_start  = 1'b0;
        i_valid  = 1'b0;
        i_last   = 1'b0;
        i_data   = '0;
        i_key    = '0;
        i_iv     = '0;
        i_dir    = DIR_ENCRYPT;
        data_chk = 1'b1;
        tag_mode = TAG_EQUAL;
        tag_val  = '0;
        repeat (RESET_CYCLES) @(negedge i_clock);
        i_reset = 1'b0;

        // Known answer with one zero block
        ref_blk[0] = CT0;
        check_block("gcm_ref_tag", gcm_ref_tag(H0, MASK0, ref_blk, 1), TAG0);
        tx_blk[0]  = '0;
        exp_blk[0] = CT0;
        tag_val    = TAG0;
        send_packet('0, '0, DIR_ENCRYPT, 1, 1'b0);
        wait_drain();

        // Six zero blocks give the keystream
        for (int i = 0; i < 6; i++) begin
            tx_blk[i] = '0;
        end
        data_chk = 1'b0;
        tag_mode = TAG_CAPTURE;
        send_packet('0, '0, DIR_ENCRYPT, 6, 1'b0);
        wait_drain();
        for (int i = 0; i < 6; i++) begin
            ks[i] = rx_cap[i];
        end
        check_block("keystream[0]", ks[0], CT0);
        check_block("o_tag", last_tag, gcm_ref_tag(H0, MASK0, ks, 6));

        // Random plaintext with gaps
        for (int i = 0; i < 6; i++) begin
            pt3[i]     = rand_block();
            ct3[i]     = pt3[i] ^ ks[i];
            tx_blk[i]  = pt3[i];
            exp_blk[i] = ct3[i];
        end
        tag3     = gcm_ref_tag(H0, MASK0, ct3, 6);
        data_chk = 1'b1;
        tag_mode = TAG_EQUAL;
        tag_val  = tag3;
        send_packet('0, '0, DIR_ENCRYPT, 6, 1'b1);
        wait_drain();

        // Decrypt the same ciphertext
        for (int i = 0; i < 6; i++) begin
            tx_blk[i]  = ct3[i];
            exp_blk[i] = pt3[i];
        end
        send_packet('0, '0, DIR_DECRYPT, 6, 1'b1);
        wait_drain();

        // Encrypt then decrypt under a random key and IV
        key5 = rand_block();
        iv5  = rand_block();
        for (int i = 0; i < 4; i++) begin
            pt5[i]    = rand_block();
            tx_blk[i] = pt5[i];
        end
        data_chk = 1'b0;
        tag_mode = TAG_CAPTURE;
        send_packet(key5, iv5[95:0], DIR_ENCRYPT, 4, 1'b0);
        wait_drain();
        tag5 = last_tag;
        for (int i = 0; i < 4; i++) begin
            ct5[i]     = rx_cap[i];
            tx_blk[i]  = ct5[i];
            exp_blk[i] = pt5[i];
        end
        data_chk = 1'b1;
        tag_mode = TAG_EQUAL;
        tag_val  = tag5;
        send_packet(key5, iv5[95:0], DIR_DECRYPT, 4, 1'b0);
        wait_drain();
        tx_blk[2][77]  = ~tx_blk[2][77];                // CTR flips the same plaintext bit
        exp_blk[2][77] = ~exp_blk[2][77];
        tag_mode       = TAG_DIFFER;
        send_packet(key5, iv5[95:0], DIR_DECRYPT, 4, 1'b0);
        wait_drain();

        // Three packets at the minimum spacing
        for (int i = 0; i < 3; i++) begin
            pt6[i]     = rand_block();
            tx_blk[i]  = pt6[i];
            exp_blk[i] = pt6[i] ^ ks[i];
            ref_blk[i] = exp_blk[i];
        end
        tag_mode = TAG_EQUAL;
        tag_val  = gcm_ref_tag(H0, MASK0, ref_blk, 3);
        send_packet('0, '0, DIR_ENCRYPT, 3, 1'b0);
        for (int i = 0; i < 2; i++) begin
            tx_blk[i]  = ct3[i];
            exp_blk[i] = pt3[i];
        end
        tag_val = gcm_ref_tag(H0, MASK0, ct3, 2);
        send_packet('0, '0, DIR_DECRYPT, 2, 1'b0);
        for (int i = 0; i < 6; i++) begin
            tx_blk[i]  = '0;
            exp_blk[i] = ks[i];
        end
        tag_val = gcm_ref_tag(H0, MASK0, ks, 6);
        send_packet('0, '0, DIR_ENCRYPT, 6, 1'b0);
        wait_drain();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: hw/aes_cipher_pipe.sv
`timescale 1ns/1ps

module aes_cipher_pipe (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_valid,
    input  gcm_pkg::cipher_req_t i_req,
    output logic                 o_valid,
    output gcm_pkg::cipher_rsp_t o_rsp
);
    import gcm_pkg::*;

    logic        stage_valid [N_ROUNDS+1];              // Index 0 is the pipe input
    cipher_req_t stage_req [N_ROUNDS+1];

    assign stage_valid[0] = i_valid;

    // Initial AddRoundKey, combinational into round 1
    assign stage_req[0] = '{
        block: i_req.block ^ i_req.key,
        key:   i_req.key,
        kind:  i_req.kind,
        last:  i_req.last
    };

    generate
        for (genvar gi = 0; gi < N_ROUNDS; gi++) begin : g_round
            aes_round u_round (
                .i_clock (i_clock),
                .i_reset (i_reset),
                .i_valid (stage_valid[gi]),
                .i_req   (stage_req[gi]),
                .i_rcon  (AES_RCON[(N_ROUNDS-1-gi)*8 +: 8]), // Round gi+1 constant
                .i_final (gi == N_ROUNDS - 1),          // No MixColumns in round 10
                .o_valid (stage_valid[gi+1]),
                .o_req   (stage_req[gi+1])
            );
        end
    endgenerate

    assign o_valid = stage_valid[N_ROUNDS];

    // Last round key is dropped here
    assign o_rsp = '{
        block: stage_req[N_ROUNDS].block,
        kind:  stage_req[N_ROUNDS].kind,
        last:  stage_req[N_ROUNDS].last
    };

endmodule

// File: hw/aes_round.sv
`timescale 1ns/1ps

module aes_round (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_valid,
    input  gcm_pkg::cipher_req_t i_req,
    input  logic [7:0]           i_rcon,
    input  logic                 i_final,
    output logic                 o_valid,
    output gcm_pkg::cipher_req_t o_req
);
    import gcm_pkg::*;

    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00); // Multiply by x mod AES poly
    endfunction

    function automatic logic [7:0] gf8_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc ^= p;
            end
            p = xtime(p);
        end
        return acc;
    endfunction

    // Inverse as a^254, zero maps to zero on its own
    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] inv;
        logic [7:0] p;
        inv = 8'h01;
        p   = a;
        for (int i = 1; i < 8; i++) begin
            p   = gf8_mul(p, p);                        // a^2, a^4 ... a^128
            inv = gf8_mul(inv, p);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63; // Affine map
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    logic [7:0]          sub_b [16];                    // After SubBytes
    logic [7:0]          shf_b [16];                    // After ShiftRows
    logic [7:0]          mix_b [16];                    // After MixColumns
    logic [31:0]         kw [4];                        // Carried key words
    logic [31:0]         nk [4];                        // Next round key words
    logic [NB_KEY-1:0]   next_key;
    logic [NB_BLOCK-1:0] state_out;

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sub_b[i] = sbox(i_req.block[NB_BLOCK-1-8*i -: 8]); // Byte 0 at the top
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shf_b[4*c+r] = sub_b[4*((c+r)%4)+r];    // Row r rotates left by r
            end
        end
        for (int c = 0; c < 4; c++) begin
            mix_b[4*c]   = xtime(shf_b[4*c]) ^ xtime(shf_b[4*c+1]) ^ shf_b[4*c+1]
                         ^ shf_b[4*c+2] ^ shf_b[4*c+3];
            mix_b[4*c+1] = shf_b[4*c] ^ xtime(shf_b[4*c+1]) ^ xtime(shf_b[4*c+2])
                         ^ shf_b[4*c+2] ^ shf_b[4*c+3];
            mix_b[4*c+2] = shf_b[4*c] ^ shf_b[4*c+1] ^ xtime(shf_b[4*c+2])
                         ^ xtime(shf_b[4*c+3]) ^ shf_b[4*c+3];
            mix_b[4*c+3] = xtime(shf_b[4*c]) ^ shf_b[4*c] ^ shf_b[4*c+1]
                         ^ shf_b[4*c+2] ^ xtime(shf_b[4*c+3]);
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            kw[i] = i_req.key[NB_KEY-1-32*i -: 32];
        end
        nk[0] = kw[0] ^ sub_word({kw[3][23:0], kw[3][31:24]}) ^ {i_rcon, 24'h0};
        nk[1] = kw[1] ^ nk[0];
        nk[2] = kw[2] ^ nk[1];
        nk[3] = kw[3] ^ nk[2];
        next_key = {nk[0], nk[1], nk[2], nk[3]};
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            state_out[NB_BLOCK-1-8*i -: 8] = i_final ? shf_b[i] : mix_b[i]; // Last round skips mix
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock) begin
        o_req.block <= state_out ^ next_key;            // AddRoundKey
        o_req.key   <= next_key;                        // Next stage expands from here
        o_req.kind  <= i_req.kind;
        o_req.last  <= i_req.last;
    end

endmodule

// File: hw/gcm_core.sv
`timescale 1ns/1ps

module gcm_core (
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_start,    // Key and IV strobe, no data
    input  logic                            i_valid,    // Data beat
    input  logic                            i_last,     // Final data beat
    input  logic [gcm_pkg::NB_BLOCK-1:0]    i_data,
    input  logic [gcm_pkg::NB_KEY-1:0]      i_key,
    input  logic [gcm_pkg::NB_IV-1:0]       i_iv,
    input  gcm_pkg::gcm_dir_e               i_dir,
    output logic                            o_valid,
    output logic [gcm_pkg::NB_BLOCK-1:0]    o_data,
    output logic                            o_start,
    output logic                            o_last,
    output logic                            o_tag_ready,
    output logic [gcm_pkg::NB_BLOCK-1:0]    o_tag
);
    import gcm_pkg::*;

    logic        issue;                                 // Block into the cipher pipe
    cipher_req_t req;
    logic        rsp_valid;
    cipher_rsp_t rsp;
    ghash_cmd_t  ghash_cmd;

    gcm_ctr_ctrl u_ctrl (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .i_data      (i_data),
        .i_key       (i_key),
        .i_iv        (i_iv),
        .i_dir       (i_dir),
        .o_issue     (issue),
        .o_req       (req),
        .i_rsp_valid (rsp_valid),
        .i_rsp       (rsp),
        .o_ghash     (ghash_cmd),
        .o_valid     (o_valid),
        .o_data      (o_data),
        .o_start     (o_start),
        .o_last      (o_last)
    );

    aes_cipher_pipe u_cipher (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (issue),
        .i_req   (req),
        .o_valid (rsp_valid),
        .o_rsp   (rsp)
    );

    ghash_unit u_ghash (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_cmd       (ghash_cmd),
        .o_tag       (o_tag),
        .o_tag_valid (o_tag_ready)
    );

endmodule

// File: hw/gcm_ctr_ctrl.sv
`timescale 1ns/1ps

module gcm_ctr_ctrl (
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_start,
    input  logic                            i_valid,
    input  logic                            i_last,
    input  logic [gcm_pkg::NB_BLOCK-1:0]    i_data,
    input  logic [gcm_pkg::NB_KEY-1:0]      i_key,
    input  logic [gcm_pkg::NB_IV-1:0]       i_iv,
    input  gcm_pkg::gcm_dir_e               i_dir,
    output logic                            o_issue,
    output gcm_pkg::cipher_req_t            o_req,
    input  logic                            i_rsp_valid,
    input  gcm_pkg::cipher_rsp_t            i_rsp,
    output gcm_pkg::ghash_cmd_t             o_ghash,
    output logic                            o_valid,
    output logic [gcm_pkg::NB_BLOCK-1:0]    o_data,
    output logic                            o_start,
    output logic                            o_last
);
    import gcm_pkg::*;

    logic [NB_KEY-1:0]   key_q;                         // Packet key
    logic [NB_IV-1:0]    iv_q;
    gcm_dir_e            dir_q;
    logic [NB_CTR-1:0]   ctr_q;                         // Next text counter
    logic [NB_LEN-1:0]   len_bits_q;                    // Ciphertext length in bits
    logic                tagmask_pend;                  // Cycle after the last beat
    logic                last_abs_q;                    // Last absorb is on the GHASH port
    logic [NB_BLOCK-1:0] mask_q;                        // Cipher of IV with counter 1
    logic [NB_BLOCK-1:0] dly_data [CIPHER_LAT];         // Waits for its keystream
    logic                dly_first [CIPHER_LAT];
    logic                text_rsp;
    logic                hkey_rsp;
    logic                mask_rsp;
    logic [NB_BLOCK-1:0] xor_data;                      // Data XOR keystream
    logic [NB_BLOCK-1:0] ct_data;                       // Ciphertext for GHASH
    logic                load_h_q;
    logic                absorb_q;
    logic                length_q;
    logic                finish_q;
    logic [NB_BLOCK-1:0] operand_q;

    // Issue arbitration, spacing rules keep these apart
    assign o_issue = i_start | i_valid | tagmask_pend;

    always_comb begin
        o_req = '{block: {iv_q, NB_CTR'(1)}, key: key_q, kind: BLK_TAGMASK, last: 1'b0};
        if (i_start) begin
            o_req = '{block: '0, key: i_key, kind: BLK_HASHKEY, last: 1'b0}; // H = E(K, 0)
        end else if (i_valid) begin
            o_req = '{block: {iv_q, ctr_q}, key: key_q, kind: BLK_TEXT, last: i_last};
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_start) begin
            key_q <= i_key;
            iv_q  <= i_iv;
            dir_q <= i_dir;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            ctr_q        <= '0;
            len_bits_q   <= '0;
            tagmask_pend <= 1'b0;
        end else begin
            tagmask_pend <= i_valid & i_last;
            if (i_start) begin
                ctr_q      <= NB_CTR'(2);               // Counter 1 is kept for the mask
                len_bits_q <= '0;
            end else if (i_valid) begin
                ctr_q      <= ctr_q + 1'b1;             // Standard 32-bit increment
                len_bits_q <= len_bits_q + NB_LEN'(NB_BLOCK);
            end
        end
    end

    always_ff @(posedge i_clock) begin
        dly_data[0]  <= i_data;
        dly_first[0] <= (ctr_q == NB_CTR'(2));          // First beat still sees counter 2
        for (int i = 1; i < CIPHER_LAT; i++) begin
            dly_data[i]  <= dly_data[i-1];
            dly_first[i] <= dly_first[i-1];
        end
    end

    assign text_rsp = i_rsp_valid && (i_rsp.kind == BLK_TEXT);
    assign hkey_rsp = i_rsp_valid && (i_rsp.kind == BLK_HASHKEY);
    assign mask_rsp = i_rsp_valid && (i_rsp.kind == BLK_TAGMASK);
    assign xor_data = dly_data[CIPHER_LAT-1] ^ i_rsp.block;
    assign ct_data  = (dir_q == DIR_ENCRYPT) ? xor_data : dly_data[CIPHER_LAT-1];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_start <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            o_valid <= text_rsp;
            o_start <= text_rsp & dly_first[CIPHER_LAT-1];
            o_last  <= text_rsp & i_rsp.last;
        end
    end

    always_ff @(posedge i_clock) begin
        if (text_rsp) begin
            o_data <= xor_data;
        end
        if (mask_rsp) begin
            mask_q <= i_rsp.block;                      // Held until finish
        end
    end

    // GHASH sequence: load_h, absorb per beat, length, finish
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            load_h_q   <= 1'b0;
            absorb_q   <= 1'b0;
            length_q   <= 1'b0;
            finish_q   <= 1'b0;
            last_abs_q <= 1'b0;
        end else begin
            load_h_q   <= hkey_rsp;
            absorb_q   <= text_rsp;
            last_abs_q <= text_rsp & i_rsp.last;
            length_q   <= last_abs_q;                   // One cycle after the last absorb
            finish_q   <= length_q;
        end
    end

    always_ff @(posedge i_clock) begin
        if (hkey_rsp) begin
            operand_q <= i_rsp.block;
        end else if (text_rsp) begin
            operand_q <= ct_data;
        end else if (last_abs_q) begin
            operand_q <= {{(NB_BLOCK-NB_LEN){1'b0}}, len_bits_q}; // No AAD, upper half zero
        end else if (length_q) begin
            operand_q <= mask_q;
        end
    end

    assign o_ghash = '{
        load_h:  load_h_q,
        absorb:  absorb_q,
        length:  length_q,
        finish:  finish_q,
        operand: operand_q
    };

endmodule

// File: hw/gcm_pkg.sv
package gcm_pkg;

    localparam int NB_BLOCK   = 128;                    // Cipher block width
    localparam int NB_KEY     = 128;                    // AES-128 only
    localparam int NB_IV      = 96;                     // Standard GCM IV
    localparam int NB_CTR     = NB_BLOCK - NB_IV;       // 32-bit block counter
    localparam int NB_LEN     = 64;                     // Bit count half of length block
    localparam int N_ROUNDS   = 10;                     // AES-128 round count
    localparam int CIPHER_LAT = N_ROUNDS;               // One register per round
    localparam int DATA_LAT   = CIPHER_LAT + 1;         // Input beat to output beat
    localparam int TAG_LAT    = 14;                     // Last input beat to tag strobe

    // Round constants, round 1 in the top byte
    localparam logic [N_ROUNDS*8-1:0] AES_RCON = 80'h01_02_04_08_10_20_40_80_1b_36;

    localparam logic [NB_BLOCK-1:0] GHASH_R = {8'he1, 120'h0}; // GF(2^128) reduction

    typedef enum logic {
        DIR_DECRYPT = 1'b0,
        DIR_ENCRYPT = 1'b1
    } gcm_dir_e;

    typedef enum logic [1:0] {
        BLK_HASHKEY = 2'd0,                             // Zero block, gives H
        BLK_TEXT    = 2'd1,                             // Counter block for a data beat
        BLK_TAGMASK = 2'd2                              // Counter 1 block, masks the tag
    } blk_kind_e;

    typedef struct packed {
        logic [NB_BLOCK-1:0] block;                     // State or plain counter block
        logic [NB_KEY-1:0]   key;                       // Round key for the next stage
        blk_kind_e           kind;                      // What the block is for
        logic                last;                      // Final data beat of a packet
    } cipher_req_t;

    typedef struct packed {
        logic [NB_BLOCK-1:0] block;                     // Cipher output
        blk_kind_e           kind;
        logic                last;
    } cipher_rsp_t;

    typedef struct packed {
        logic                load_h;                    // Take operand as H, clear accumulator
        logic                absorb;                    // Fold ciphertext block
        logic                length;                    // Fold length block
        logic                finish;                    // Operand is the tag mask
        logic [NB_BLOCK-1:0] operand;
    } ghash_cmd_t;

endpackage

// File: hw/ghash_unit.sv
`timescale 1ns/1ps

module ghash_unit (
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  gcm_pkg::ghash_cmd_t             i_cmd,
    output logic [gcm_pkg::NB_BLOCK-1:0]    o_tag,
    output logic                            o_tag_valid
);
    import gcm_pkg::*;

    // GCM right-shift multiply, bit 127 is the first bit of the block
    function automatic logic [NB_BLOCK-1:0] gf_mult(
        input logic [NB_BLOCK-1:0] x,
        input logic [NB_BLOCK-1:0] y
    );
        logic [NB_BLOCK-1:0] z;
        logic [NB_BLOCK-1:0] v;
        z = '0;
        v = y;
        for (int i = 0; i < NB_BLOCK; i++) begin
            if (x[NB_BLOCK-1-i]) begin
                z ^= v;                                 // Add current multiple of y
            end
            if (v[0]) begin
                v = (v >> 1) ^ GHASH_R;                 // Shift out and reduce
            end else begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

    logic [NB_BLOCK-1:0] h_q;                           // Hash key for this packet
    logic [NB_BLOCK-1:0] acc_q;                         // Running GHASH value

    always_ff @(posedge i_clock) begin
        if (i_cmd.load_h) begin
            h_q <= i_cmd.operand;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_cmd.load_h) begin
            acc_q <= '0;                                // New packet
        end else if (i_cmd.absorb || i_cmd.length) begin
            acc_q <= gf_mult(acc_q ^ i_cmd.operand, h_q);
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_cmd.finish) begin
            o_tag <= acc_q ^ i_cmd.operand;             // Operand carries the tag mask
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_tag_valid <= 1'b0;
        end else begin
            o_tag_valid <= i_cmd.finish;
        end
    end

endmodule

// File: tb.f
+incdir+dv
hw/gcm_pkg.sv
hw/aes_round.sv
hw/aes_cipher_pipe.sv
hw/ghash_unit.sv
hw/gcm_ctr_ctrl.sv
hw/gcm_core.sv
dv/gcm_tb.sv
